/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = memorySubsystemTb
FILELIST = compile.f
BUILD_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(BUILD_DIR)

/* common/memPkg.sv */
package memPkg;

  // Page geometry for 1 KiB pages
  parameter int unsigned PAGE_OFFSET_BITS = 10;
  parameter int unsigned PAGE_BITS = 22;

  // Buffer slot index comes from address bits 13:10
  parameter int unsigned TLB_INDEX_BITS = 4;

  // Single-level table with 256 entries, address bits 17:10
  parameter int unsigned PT_INDEX_BITS = 8;

  // Two words per table entry
  // Word 0 holds the virtual page, word 1 the physical page
  parameter int unsigned PT_ENTRY_BYTES = 8;
  parameter int unsigned WORD_BYTES = 4;

  typedef logic [31:0] addrT;
  typedef logic [31:0] dataT;
  typedef logic [PAGE_BITS-1:0] pageT;
  typedef logic [PAGE_OFFSET_BITS-1:0] offsetT;
  typedef logic [TLB_INDEX_BITS-1:0] tlbIndexT;
  typedef logic [PT_INDEX_BITS-1:0] ptIndexT;

  // Controller states
  // physWait states cover one RAM round trip
  // ptWait states cover the two table word reads
  typedef enum logic [2:0] {
    ready,
    physWait1,
    physWait2,
    ptWait1,
    ptWait2,
    ptWait3,
    ptWait4
  } mcStateT;

endpackage

/* compile.f */
common/memPkg.sv
hw/physicalRam.sv
memoryController/translationBuffer.sv
memoryController/memoryController.sv
hw/memorySubsystem.sv
tests/memoryController_assertions.sv
tests/memorySubsystemTb.sv

/* hw/memorySubsystem.sv */
`timescale 1ns/10ps

module memorySubsystem import memPkg::*; #(
  parameter int unsigned ramAddrBits = 12,
  parameter int unsigned tlbEntries = 16
) (
  input  logic clk,
  input  logic reset,
  input  addrT mcRamAddress,
  input  dataT mcRamIn,
  input  logic mcReadReq,
  input  logic mcWriteReq,
  input  logic mcAddrVirtual,
  input  addrT ptAddress,
  output dataT mcRamOut,
  output logic mcRamReady
);

  // Controller to RAM
  addrT phRamAddress;
  dataT phRamOut;
  dataT phRamIn;
  logic phReadReq;
  logic phWriteReq;

  // Controller to buffer
  addrT lookupAddr;
  logic lookupHit;
  pageT lookupPhysPage;
  logic fillEn;
  tlbIndexT fillIndex;
  pageT fillVirtPage;
  pageT fillPhysPage;

  memoryController #(
    .tlbEntries(tlbEntries)
  ) u_controller (
    .clk(clk),
    .reset(reset),
    .mcRamAddress(mcRamAddress),
    .mcRamIn(mcRamIn),
    .mcReadReq(mcReadReq),
    .mcWriteReq(mcWriteReq),
    .mcAddrVirtual(mcAddrVirtual),
    .ptAddress(ptAddress),
    .phRamIn(phRamIn),
    .lookupHit(lookupHit),
    .lookupPhysPage(lookupPhysPage),
    .mcRamOut(mcRamOut),
    .mcRamReady(mcRamReady),
    .phRamAddress(phRamAddress),
    .phRamOut(phRamOut),
    .phReadReq(phReadReq),
    .phWriteReq(phWriteReq),
    .lookupAddr(lookupAddr),
    .fillEn(fillEn),
    .fillIndex(fillIndex),
    .fillVirtPage(fillVirtPage),
    .fillPhysPage(fillPhysPage)
  );

  translationBuffer #(
    .tlbEntries(tlbEntries)
  ) u_tlb (
    .clk(clk),
    .reset(reset),
    .lookupAddr(lookupAddr),
    .fillEn(fillEn),
    .fillIndex(fillIndex),
    .fillVirtPage(fillVirtPage),
    .fillPhysPage(fillPhysPage),
    .lookupHit(lookupHit),
    .lookupPhysPage(lookupPhysPage)
  );

  // Behavioral RAM, no reset
  physicalRam #(
    .ramAddrBits(ramAddrBits)
  ) u_ram (
    .clk(clk),
    .phRamAddress(phRamAddress),
    .phRamOut(phRamOut),
    .phReadReq(phReadReq),
    .phWriteReq(phWriteReq),
    .phRamIn(phRamIn)
  );

endmodule

/* hw/physicalRam.sv */
`timescale 1ns/10ps

module physicalRam import memPkg::*; #(
  parameter int unsigned ramAddrBits = 12
) (
  input  logic clk,
  input  addrT phRamAddress,
  input  dataT phRamOut,
  input  logic phReadReq,
  input  logic phWriteReq,
  output dataT phRamIn
);

  localparam int unsigned ramWords = 2 ** ramAddrBits;

  // Word array, contents undefined at power up
  dataT mem [ramWords];

  // Byte address to word address
  logic [ramAddrBits-1:0] wordAddr;

  assign wordAddr = phRamAddress[ramAddrBits+1:2];

  // Writes land on the strobe edge
  always_ff @(posedge clk)
  begin
    if (phWriteReq)
      mem[wordAddr] <= phRamOut;
  end

  // Registered read, one cycle of latency
  // Output holds until the next read strobe
  always_ff @(posedge clk)
  begin
    if (phReadReq)
      phRamIn <= mem[wordAddr];
  end

endmodule

/* memoryController/memoryController.sv */
`timescale 1ns/10ps

module memoryController import memPkg::*; #(
  parameter int unsigned tlbEntries = 16
) (
  input  logic     clk,
  input  logic     reset,
  input  addrT     mcRamAddress,
  input  dataT     mcRamIn,
  input  logic     mcReadReq,
  input  logic     mcWriteReq,
  input  logic     mcAddrVirtual,
  input  addrT     ptAddress,
  input  dataT     phRamIn,
  input  logic     lookupHit,
  input  pageT     lookupPhysPage,
  output dataT     mcRamOut,
  output logic     mcRamReady,
  output addrT     phRamAddress,
  output dataT     phRamOut,
  output logic     phReadReq,
  output logic     phWriteReq,
  output addrT     lookupAddr,
  output logic     fillEn,
  output tlbIndexT fillIndex,
  output pageT     fillVirtPage,
  output pageT     fillPhysPage
);

  localparam int unsigned tlbIndexBits = $clog2(tlbEntries);

  mcStateT state;

  // Control state, cleared by reset
  logic isRead;
  logic savedReadReq;
  logic savedWriteReq;

  // Request saved across a table walk
  addrT savedAddr;
  dataT savedData;
  dataT savedFirstWord;

  // Decode of the live request
  logic requestValid;
  logic requestRead;
  logic requestWrite;
  logic directAccess;
  ptIndexT requestPtIndex;
  addrT ptEntryAddr;
  addrT hitAddr;
  offsetT savedOffset;

  assign requestValid = mcReadReq | mcWriteReq;

  // Read wins if both strobes show up together
  assign requestRead = mcReadReq;
  assign requestWrite = mcWriteReq & ~mcReadReq;

  // Physical requests and buffer hits skip the table walk
  assign directAccess = ~mcAddrVirtual | lookupHit;

  // Buffer lookup runs on the live address
  assign lookupAddr = mcRamAddress;

  // Table entry 0 word for the requested page
  assign requestPtIndex = mcRamAddress[PAGE_OFFSET_BITS +: PT_INDEX_BITS];
  assign ptEntryAddr = ptAddress + addrT'(requestPtIndex) * addrT'(PT_ENTRY_BYTES);

  // Translated address on a hit keeps the page offset
  assign hitAddr = {lookupPhysPage, mcRamAddress[PAGE_OFFSET_BITS-1:0]};

  assign savedOffset = savedAddr[PAGE_OFFSET_BITS-1:0];

  // Fill happens on the edge that captures word 1
  assign fillEn = (state == ptWait4);
  assign fillIndex = savedAddr[PAGE_OFFSET_BITS +: tlbIndexBits];
  assign fillVirtPage = savedFirstWord[PAGE_BITS-1:0];
  assign fillPhysPage = phRamIn[PAGE_BITS-1:0];

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state <= ready;
      mcRamReady <= 1'b0;
      phReadReq <= 1'b0;
      phWriteReq <= 1'b0;
      isRead <= 1'b0;
      savedReadReq <= 1'b0;
      savedWriteReq <= 1'b0;
    end
    else
    begin
      // Strobes and completion are single pulses
      mcRamReady <= 1'b0;
      phReadReq <= 1'b0;
      phWriteReq <= 1'b0;
      case (state)
        ready:
        begin
          if (requestValid)
          begin
            if (directAccess)
            begin
              phReadReq <= requestRead;
              phWriteReq <= requestWrite;
              isRead <= requestRead;
              state <= physWait1;
            end
            else
            begin
              // Miss, start on word 0 of the table entry
              phReadReq <= 1'b1;
              savedReadReq <= requestRead;
              savedWriteReq <= requestWrite;
              state <= ptWait1;
            end
          end
        end
        physWait1:
          state <= physWait2;
        physWait2:
        begin
          mcRamReady <= 1'b1;
          state <= ready;
        end
        ptWait1:
          state <= ptWait2;
        ptWait2:
        begin
          // Word 0 arrives, ask for word 1
          phReadReq <= 1'b1;
          state <= ptWait3;
        end
        ptWait3:
          state <= ptWait4;
        ptWait4:
        begin
          // Replay the original request with the new translation
          phReadReq <= savedReadReq;
          phWriteReq <= savedWriteReq;
          isRead <= savedReadReq;
          state <= physWait1;
        end
        default:
          state <= ready;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    case (state)
      ready:
      begin
        if (requestValid)
        begin
          savedAddr <= mcRamAddress;
          savedData <= mcRamIn;
          if (!mcAddrVirtual)
          begin
            phRamAddress <= mcRamAddress;
            phRamOut <= mcRamIn;
          end
          else if (lookupHit)
          begin
            phRamAddress <= hitAddr;
            phRamOut <= mcRamIn;
          end
          else
            phRamAddress <= ptEntryAddr;
        end
      end
      physWait2:
      begin
        // Hold the last read value for the requester
        if (isRead)
          mcRamOut <= phRamIn;
      end
      ptWait2:
      begin
        savedFirstWord <= phRamIn;
        phRamAddress <= phRamAddress + addrT'(WORD_BYTES);
      end
      ptWait4:
      begin
        phRamAddress <= {phRamIn[PAGE_BITS-1:0], savedOffset};
        phRamOut <= savedData;
      end
      default:
      begin
      end
    endcase
  end

endmodule

/* memoryController/translationBuffer.sv */
`timescale 1ns/10ps

module translationBuffer import memPkg::*; #(
  parameter int unsigned tlbEntries = 16
) (
  input  logic     clk,
  input  logic     reset,
  input  addrT     lookupAddr,
  input  logic     fillEn,
  input  tlbIndexT fillIndex,
  input  pageT     fillVirtPage,
  input  pageT     fillPhysPage,
  output logic     lookupHit,
  output pageT     lookupPhysPage
);

  localparam int unsigned tlbIndexBits = $clog2(tlbEntries);

  // Per slot storage
  pageT tagStore [tlbEntries];
  pageT physStore [tlbEntries];
  logic [tlbEntries-1:0] slotValid;

  // Direct mapped, the low page bits pick the slot
  tlbIndexT lookupIndex;
  pageT lookupPage;

  assign lookupIndex = lookupAddr[PAGE_OFFSET_BITS +: tlbIndexBits];
  assign lookupPage = lookupAddr[31:PAGE_OFFSET_BITS];

  // Hit needs a valid slot with a matching tag
  assign lookupHit = slotValid[lookupIndex] && (tagStore[lookupIndex] == lookupPage);
  assign lookupPhysPage = physStore[lookupIndex];

  // Valid bits come up clear so no stale translation survives reset
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      slotValid <= '0;
    else if (fillEn)
      slotValid[fillIndex] <= 1'b1;
  end

  // Tag and page payload
  // A fill simply overwrites whatever the slot held
  always_ff @(posedge clk)
  begin
    if (fillEn)
    begin
      tagStore[fillIndex] <= fillVirtPage;
      physStore[fillIndex] <= fillPhysPage;
    end
  end

endmodule

/* tests/memoryController_assertions.sv */
`timescale 1ns/10ps

module memoryControllerAssertions import memPkg::*; (
  input logic    clk,
  input logic    reset,
  input mcStateT state,
  input logic    mcRamReady,
  input logic    phReadReq,
  input logic    phWriteReq,
  input addrT    phRamAddress
);

  // Completion is a single pulse
  readyIsPulse: assert property (@(posedge clk) disable iff (reset)
    mcRamReady |=> !mcRamReady)
    else $error("mcRamReady stayed high for two cycles");

  // RAM never sees a read and a write at once
  strobesExclusive: assert property (@(posedge clk) disable iff (reset)
    !(phReadReq && phWriteReq))
    else $error("phReadReq and phWriteReq high together");

  // While busy the RAM address moves only when the walk steps to the next word
  // or to the translated access
  busyAddressStable: assert property (@(posedge clk) disable iff (reset)
    (state != ready && state != ptWait2 && state != ptWait4) |=> $stable(phRamAddress))
    else $error("phRamAddress changed while the controller was busy");

endmodule

bind memoryController memoryControllerAssertions u_assertions (
  .clk(clk),
  .reset(reset),
  .state(state),
  .mcRamReady(mcRamReady),
  .phReadReq(phReadReq),
  .phWriteReq(phWriteReq),
  .phRamAddress(phRamAddress)
);

/* tests/memorySubsystemTb.sv */
`timescale 1ns/10ps

module memorySubsystemTb import memPkg::*; ();

  localparam int clkPeriod = 20;
  localparam int ramAddrBits = 12;
  localparam int ramWords = 2 ** ramAddrBits;
  localparam int readyTimeout = 20;

  // Budget of about 125 accesses at up to 8 cycles each
  localparam int accessBudget = 125;
  localparam int cyclesPerAccess = 8;
  localparam int watchdogNs = accessBudget * cyclesPerAccess * clkPeriod;

  // Page table sits above the region used by random accesses
  localparam addrT ptBase = 32'h0000_3000;
  localparam int randomWords = 3072;

  // Two virtual pages that share buffer slot 5
  localparam pageT vPageA = 22'h000025;
  localparam pageT vPageB = 22'h000035;
  localparam pageT pPageA = 22'd4;
  localparam pageT pPageNew = 22'd6;
  localparam pageT pPageB = 22'd7;
  localparam offsetT offA = 10'h0a8;
  localparam offsetT offA2 = 10'h3fc;

  logic clk;
  logic reset;
  addrT mcRamAddress;
  dataT mcRamIn;
  logic mcReadReq;
  logic mcWriteReq;
  logic mcAddrVirtual;
  addrT ptAddress;
  dataT mcRamOut;
  logic mcRamReady;

  // Reference copy of RAM built from the testbench's own writes
  dataT refMem [ramWords];
  bit refKnown [ramWords];

  int errorCount;
  int checkCount;
  int testCount;
  int failedTests;
  int testErrorsAtStart;

  memorySubsystem #(
    .ramAddrBits(ramAddrBits),
    .tlbEntries(16)
  ) u_dut (
    .clk(clk),
    .reset(reset),
    .mcRamAddress(mcRamAddress),
    .mcRamIn(mcRamIn),
    .mcReadReq(mcReadReq),
    .mcWriteReq(mcWriteReq),
    .mcAddrVirtual(mcAddrVirtual),
    .ptAddress(ptAddress),
    .mcRamOut(mcRamOut),
    .mcRamReady(mcRamReady)
  );

  initial clk = 1'b0;
  always #(clkPeriod / 2) clk = ~clk;

  function automatic int wordIndex(addrT addr);
    return int'(addr[ramAddrBits+1:2]);
  endfunction

  task automatic reportMismatch(string what, logic [31:0] got, logic [31:0] expected);
    errorCount++;
    $display("MISMATCH at %0d ns: %s, got %h expected %h", $time, what, got, expected);
  endtask

  task automatic applyReset;
    reset = 1'b1;
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
  endtask

  // One-cycle strobe, then count edges up to the completion pulse
  task automatic issueAndWait(input logic isWrite, input logic isVirtual, input addrT addr,
                              input dataT wdata, output int edges, output bit timedOut);
    bit done;
    @(posedge clk);
    #1;
    mcRamAddress = addr;
    mcRamIn = wdata;
    mcAddrVirtual = isVirtual;
    mcReadReq = !isWrite;
    mcWriteReq = isWrite;
    edges = 0;
    done = 1'b0;
    while (!done)
    begin
      @(posedge clk);
      #1;
      edges++;
      mcReadReq = 1'b0;
      mcWriteReq = 1'b0;
      // Live inputs move away so only the saved request can complete the access
      mcRamAddress = ~addr;
      mcRamIn = ~wdata;
      if (mcRamReady || edges >= readyTimeout)
        done = 1'b1;
    end
    timedOut = !mcRamReady;
  endtask

  // Latency and data check against the reference copy
  task automatic checkAccess(string what, logic isWrite, int idx, dataT wdata, int edges,
                             bit timedOut, int expEdges);
    if (timedOut)
    begin
      errorCount++;
      $display("No completion pulse within %0d cycles for %s", readyTimeout, what);
      return;
    end
    checkCount++;
    if (edges != expEdges)
      reportMismatch({what, " latency"}, edges, expEdges);
    if (isWrite)
    begin
      refMem[idx] = wdata;
      refKnown[idx] = 1'b1;
    end
    else if (refKnown[idx])
    begin
      checkCount++;
      if (mcRamOut !== refMem[idx])
        reportMismatch({what, " data"}, mcRamOut, refMem[idx]);
    end
    else
    begin
      errorCount++;
      $display("Read of a word never written by the testbench for %s", what);
    end
  endtask

  task automatic physAccess(input logic isWrite, input addrT addr, input dataT wdata,
                            input int expEdges);
    int edges;
    bit timedOut;
    issueAndWait(isWrite, 1'b0, addr, wdata, edges, timedOut);
    checkAccess($sformatf("physical %s at %h", isWrite ? "write" : "read", addr),
                isWrite, wordIndex(addr), wdata, edges, timedOut, expEdges);
  endtask

  // Expected physical page and latency come from the test's own mapping
  task automatic virtAccess(input logic isWrite, input addrT vaddr, input dataT wdata,
                            input pageT expPage, input int expEdges);
    int edges;
    bit timedOut;
    addrT physAddr;
    physAddr = {expPage, vaddr[PAGE_OFFSET_BITS-1:0]};
    issueAndWait(isWrite, 1'b1, vaddr, wdata, edges, timedOut);
    checkAccess($sformatf("virtual %s at %h", isWrite ? "write" : "read", vaddr),
                isWrite, wordIndex(physAddr), wdata, edges, timedOut, expEdges);
  endtask

  // Entry at ptBase plus 8 times the low 8 page bits
  task automatic writeTableEntry(input pageT virtPage, input pageT physPage);
    addrT entry;
    entry = ptBase + addrT'(virtPage[7:0]) * 32'd8;
    physAccess(1'b1, entry, {10'b0, virtPage}, 3);
    physAccess(1'b1, entry + 32'd4, {10'b0, physPage}, 3);
  endtask

  task automatic startTest;
    testCount++;
    testErrorsAtStart = errorCount;
  endtask

  task automatic finishTest(string name);
    if (errorCount == testErrorsAtStart)
      $display("test %0d %s: ok", testCount, name);
    else
    begin
      failedTests++;
      $display("test %0d %s: failing with %0d errors", testCount, name,
               errorCount - testErrorsAtStart);
    end
  endtask

  task automatic testPhysReadWrite;
    startTest();
    checkCount++;
    if (mcRamReady !== 1'b0)
      reportMismatch("mcRamReady after reset", {31'b0, mcRamReady}, 32'd0);
    physAccess(1'b1, 32'h0000_0000, 32'h1234_5678, 3);
    physAccess(1'b1, 32'h0000_0104, 32'hdead_beef, 3);
    physAccess(1'b1, 32'h0000_0ffc, 32'h0bad_f00d, 3);
    physAccess(1'b1, 32'h0000_2ff8, 32'hcafe_0001, 3);
    physAccess(1'b0, 32'h0000_0000, 32'h0, 3);
    physAccess(1'b0, 32'h0000_0104, 32'h0, 3);
    physAccess(1'b0, 32'h0000_0ffc, 32'h0, 3);
    physAccess(1'b0, 32'h0000_2ff8, 32'h0, 3);
    finishTest("physical read and write");
  endtask

  task automatic testVirtFirstWrite;
    startTest();
    writeTableEntry(vPageA, pPageA);
    virtAccess(1'b1, {vPageA, offA}, 32'h5a5a_0001, pPageA, 7);
    physAccess(1'b0, {pPageA, offA}, 32'h0, 3);
    finishTest("virtual write first touch");
  endtask

  task automatic testVirtHit;
    startTest();
    virtAccess(1'b0, {vPageA, offA}, 32'h0, pPageA, 3);
    virtAccess(1'b1, {vPageA, offA2}, 32'h5a5a_0002, pPageA, 3);
    physAccess(1'b0, {pPageA, offA2}, 32'h0, 3);
    finishTest("virtual hit");
  endtask

  task automatic testStaleTranslation;
    startTest();
    // Remap page A, the valid slot still holds the old page
    writeTableEntry(vPageA, pPageNew);
    physAccess(1'b1, {pPageNew, offA}, 32'h6b6b_0003, 3);
    virtAccess(1'b0, {vPageA, offA}, 32'h0, pPageA, 3);
    // Page B shares slot 5 and evicts page A
    writeTableEntry(vPageB, pPageB);
    virtAccess(1'b1, {vPageB, offA}, 32'h7c7c_0004, pPageB, 7);
    virtAccess(1'b0, {vPageA, offA}, 32'h0, pPageNew, 7);
    finishTest("stale translation and eviction");
  endtask

  task automatic testResetClearsBuffer;
    startTest();
    @(posedge clk);
    #1;
    applyReset();
    checkCount++;
    if (mcRamReady !== 1'b0)
      reportMismatch("mcRamReady after mid-run reset", {31'b0, mcRamReady}, 32'd0);
    virtAccess(1'b0, {vPageA, offA}, 32'h0, pPageNew, 7);
    virtAccess(1'b0, {vPageA, offA}, 32'h0, pPageNew, 3);
    finishTest("reset clears buffer");
  endtask

  task automatic testRandomAccesses;
    addrT written[$];
    addrT addr;
    bit doWrite;
    startTest();
    for (int i = 0; i < 40; i++)
    begin
      doWrite = (written.size() == 0) || ($urandom % 2 == 0);
      if (doWrite)
      begin
        // Word addresses below the page table region
        addr = addrT'($urandom % randomWords) << 2;
        written.push_back(addr);
        physAccess(1'b1, addr, $urandom, 3);
      end
      else
      begin
        addr = written[$urandom % written.size()];
        physAccess(1'b0, addr, 32'h0, 3);
      end
    end
    finishTest("random physical accesses");
  endtask

  initial
  begin
    #(watchdogNs);
    $display("Watchdog expired after %0d ns, the run did not finish", watchdogNs);
    $display("TB FAILED");
    $finish;
  end

  initial
  begin
    void'($urandom(32'h66ae_24ab));
    errorCount = 0;
    checkCount = 0;
    testCount = 0;
    failedTests = 0;
    testErrorsAtStart = 0;
    mcRamAddress = '0;
    mcRamIn = '0;
    mcReadReq = 1'b0;
    mcWriteReq = 1'b0;
    mcAddrVirtual = 1'b0;
    ptAddress = ptBase;
    applyReset();
    testPhysReadWrite();
    testVirtFirstWrite();
    testVirtHit();
    testStaleTranslation();
    testResetClearsBuffer();
    testRandomAccesses();
    $display("summary: %0d tests, %0d failing, %0d checks, %0d errors",
             testCount, failedTests, checkCount, errorCount);
    if (errorCount == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule
